// ==== Makefile ====
# Verilator build and run of the generator channel testbench

BIN := obj_dir/Vasg_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): project.f $(wildcard design/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timescale 1ns/1ps --top-module asg_tb -f project.f

sim.log: $(BIN)
	$(BIN) > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/asg_cfg_pkg.sv ====
/*
  configuration types of one generator channel
  burst counters are fixed at 32 bit period and 16 bit repetition width
  length and count fields hold the wanted value minus one
*/

package asg_cfg_pkg;

  //////////////////////////////
  // counter widths
  //////////////////////////////

  // burst period counter width
  localparam int unsigned BLW = 32;
  // burst repetition counter width
  localparam int unsigned BNW = 16;

  typedef logic [BLW-1:0] burst_len_t;
  typedef logic [BNW-1:0] burst_num_t;

  //////////////////////////////
  // burst settings
  //////////////////////////////

  // 82 bits, ben is the msb
  typedef struct packed {
    logic       ben;  // burst enable
    logic       inf;  // repeat forever
    burst_len_t bdl;  // data length - 1
    burst_len_t bln;  // period length - 1
    burst_num_t bnm;  // repetitions - 1
  } burst_cfg_t;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  typedef enum logic [1:0] {
    st_idle,  // waiting for a trigger
    st_data,  // fresh table reads
    st_hold   // burst idle part, last sample repeats
  } seq_state_t;

endpackage

// ==== design/asg_io_pkg.sv ====
/*
  external traffic types of one generator channel
  sample width fixed at 14 bits, no back-pressure on the beat
*/

package asg_io_pkg;

  //////////////////////////////
  // basic vectors
  //////////////////////////////

  // one dac sample
  typedef logic [13:0] sample_t;
  // processor word address, table uses the low bits
  typedef logic [15:0] cpu_addr_t;

  //////////////////////////////
  // processor bus
  //////////////////////////////

  // 32 bits, never both strobes at once
  typedef struct packed {
    logic      wen;
    logic      ren;
    cpu_addr_t addr;
    sample_t   wdata;
  } cpu_req_t;

  // 15 bits, ack one cycle after a strobe
  typedef struct packed {
    logic    ack;
    sample_t rdata;
  } cpu_rsp_t;

  //////////////////////////////
  // output stream
  //////////////////////////////

  // 16 bits, one beat per clock while valid
  typedef struct packed {
    logic    tvalid;
    logic    tlast;
    sample_t tdata;
  } sto_beat_t;

endpackage

// ==== design/asg_sequencer.sv ====
/*
  playback control of one channel: trigger mask, burst FSM, modulo pointer
  cfg inputs must stay stable while running, triggers ignored in a run
  first valid beat leaves 3 edges after the trigger edge
*/

`timescale 1ns/1ps

module asg_sequencer
  import asg_io_pkg::*;
  import asg_cfg_pkg::*;
#(
  parameter int unsigned TN  = 2,
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 8
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // triggers
  input  logic [TN-1:0]      trg_in,
  input  logic [TN-1:0]      cfg_trg,
  // pointer setup, fixed point CWM.CWF
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_stp,
  input  logic [CWM+CWF-1:0] cfg_off,
  input  burst_cfg_t         cfg_burst,
  // table read control
  output logic [CWM-1:0]     rd_addr,
  output logic               rd_addr_en,
  output logic               rd_en,
  input  sample_t            rd_data,
  // stream and events
  output sto_beat_t          sto_out,
  output logic               trg_out,
  output logic               irq_trg,
  output logic               irq_stp
);

  localparam int unsigned PW = CWM + CWF;

  seq_state_t state;

  // burst counters and their end flags
  burst_len_t cnt_bln;
  burst_num_t cnt_bnm;
  logic       end_bdl;
  logic       end_bln;
  logic       end_bnm;

  // events
  logic trg_hit;
  logic run;
  logic rpt;
  logic evt;

  // pointer, one extra bit for the sum
  logic [PW-1:0] ptr_cur;
  logic [PW:0]   ptr_nxt;
  logic [PW:0]   siz_p1;
  logic [PW:0]   ptr_wrp;
  logic          wrap;

  // delay line matching the two stage table read
  logic vld_d;
  logic lst_d;
  logic tvld_r;
  logic tlst_r;

  //////////////////////////////
  // events
  //////////////////////////////

  assign trg_hit = |(trg_in & cfg_trg);
  assign run     = (state != st_idle);

  assign end_bdl = (cnt_bln == cfg_burst.bdl);
  assign end_bln = (cnt_bln == cfg_burst.bln);
  // never ends when infinite
  assign end_bnm = ~cfg_burst.inf & (cnt_bnm == cfg_burst.bnm);

  // period restart in burst mode
  assign rpt = run & cfg_burst.ben & end_bln;
  // start while idle, restart while running
  assign evt = run ? rpt : trg_hit;

  assign irq_trg = evt;

  //////////////////////////////
  // burst FSM
  //////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= st_idle;
      cnt_bln <= '0;
      cnt_bnm <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (trg_hit) begin
            state   <= st_data;
            cnt_bln <= '0;
            cnt_bnm <= '0;
          end
        end
        st_data, st_hold: begin
          // periodic mode stays in data
          if (cfg_burst.ben) begin
            if (end_bln) begin
              state   <= end_bnm ? st_idle : st_data;
              cnt_bln <= '0;
              // repetitions only counted in finite mode
              if (!cfg_burst.inf) begin
                cnt_bnm <= cnt_bnm + burst_num_t'(1);
              end
            end else begin
              // data part over, hold the last sample
              if (end_bdl) begin
                state <= st_hold;
              end
              cnt_bln <= cnt_bln + burst_len_t'(1);
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // read pointer
  //////////////////////////////

  assign siz_p1  = {1'b0, cfg_siz} + (PW+1)'(1);
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg_stp} + (PW+1)'(1);
  // wrap modulo table size
  assign wrap    = (ptr_nxt >= siz_p1);
  assign ptr_wrp = wrap ? ptr_nxt - siz_p1 : ptr_nxt;

  // loaded on every start, no clear needed
  always_ff @(posedge sto) begin
    if (evt) begin
      ptr_cur <= cfg_off;
    end else if (rd_addr_en) begin
      ptr_cur <= ptr_wrp[PW-1:0];
    end
  end

  assign rd_addr    = ptr_cur[CWF +: CWM];
  assign rd_addr_en = (state == st_data);

  //////////////////////////////
  // output timing
  //////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      rd_en   <= 1'b0;
      vld_d   <= 1'b0;
      lst_d   <= 1'b0;
      tvld_r  <= 1'b0;
      tlst_r  <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      // data stage one edge behind address stage
      rd_en   <= rd_addr_en;
      vld_d   <= run;
      // final cycle of the last repetition
      lst_d   <= rpt & end_bnm;
      tvld_r  <= vld_d;
      tlst_r  <= lst_d;
      trg_out <= evt;
    end
  end

  assign sto_out = '{tvalid: tvld_r, tlast: tlst_r, tdata: rd_data};
  // stop interrupt with the tlast beat
  assign irq_stp = tlst_r;

endmodule

// ==== design/asg_table.sv ====
/*
  sample table with 2**CWM entries, contents survive ctl_rst
  processor port writes on the strobe edge, read data one cycle later
  playback read is two registered stages with separate enables
*/

`timescale 1ns/1ps

module asg_table
  import asg_io_pkg::*;
#(
  parameter int unsigned CWM = 8
) (
  input  logic           sto,
  input  logic           ctl_rst,
  // processor bus
  input  cpu_req_t       cpu_req,
  output cpu_rsp_t       cpu_rsp,
  // playback port
  input  logic [CWM-1:0] rd_addr,
  input  logic           rd_addr_en,
  input  logic           rd_en,
  output sample_t        rd_data
);

  // table storage
  sample_t mem [0:2**CWM-1];

  // processor side
  logic [CWM-1:0] cpu_idx;
  sample_t        cpu_rdata;
  logic           cpu_ack;

  // playback side
  logic [CWM-1:0] addr_r;
  sample_t        data_r;

  //////////////////////////////
  // processor access
  //////////////////////////////

  // upper address bits ignored
  assign cpu_idx = cpu_req.addr[CWM-1:0];

  always_ff @(posedge sto) begin
    if (cpu_req.wen) begin
      mem[cpu_idx] <= cpu_req.wdata;
    end
  end

  // read-back
  always_ff @(posedge sto) begin
    if (cpu_req.ren) begin
      cpu_rdata <= mem[cpu_idx];
    end
  end

  // ack for either strobe
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cpu_ack <= 1'b0;
    end else begin
      cpu_ack <= cpu_req.wen | cpu_req.ren;
    end
  end

  assign cpu_rsp = '{ack: cpu_ack, rdata: cpu_rdata};

  //////////////////////////////
  // playback read
  //////////////////////////////

  // stage one address, stage two data
  // data held while rd_en low, so burst idle repeats the last sample
  always_ff @(posedge sto) begin
    if (rd_addr_en) begin
      addr_r <= rd_addr;
    end
    if (rd_en) begin
      data_r <= mem[addr_r];
    end
  end

  assign rd_data = data_r;

endmodule

// ==== design/asg_top.sv ====
/*
  one generator channel: sample table plus playback sequencer
  bus and stream share sto and ctl_rst, no back-pressure on sto_out
*/

`timescale 1ns/1ps

module asg_top
  import asg_io_pkg::*;
  import asg_cfg_pkg::*;
#(
  parameter int unsigned TN  = 2,
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 8
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // processor bus
  input  cpu_req_t           cpu_req,
  output cpu_rsp_t           cpu_rsp,
  // triggers
  input  logic [TN-1:0]      trg_in,
  input  logic [TN-1:0]      cfg_trg,
  // configuration levels
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_stp,
  input  logic [CWM+CWF-1:0] cfg_off,
  input  burst_cfg_t         cfg_burst,
  // stream and events
  output sto_beat_t          sto_out,
  output logic               trg_out,
  output logic               irq_trg,
  output logic               irq_stp
);

  // sequencer to table
  logic [CWM-1:0] rd_addr;
  logic           rd_addr_en;
  logic           rd_en;
  sample_t        rd_data;

  //////////////////////////////
  // table
  //////////////////////////////

  asg_table #(
    .CWM (CWM)
  ) asg_table_inst (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp),
    .rd_addr    (rd_addr),
    .rd_addr_en (rd_addr_en),
    .rd_en      (rd_en),
    .rd_data    (rd_data)
  );

  //////////////////////////////
  // sequencer
  //////////////////////////////

  asg_sequencer #(
    .TN  (TN),
    .CWM (CWM),
    .CWF (CWF)
  ) asg_sequencer_inst (
    .sto        (sto),
    .ctl_rst    (ctl_rst),
    .trg_in     (trg_in),
    .cfg_trg    (cfg_trg),
    .cfg_siz    (cfg_siz),
    .cfg_stp    (cfg_stp),
    .cfg_off    (cfg_off),
    .cfg_burst  (cfg_burst),
    .rd_addr    (rd_addr),
    .rd_addr_en (rd_addr_en),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .sto_out    (sto_out),
    .trg_out    (trg_out),
    .irq_trg    (irq_trg),
    .irq_stp    (irq_stp)
  );

endmodule

// ==== dv/asg_checker.sv ====
/*
  watches asg_top and compares every bus read and every output beat
  table is mirrored from the bus writes, expected beats come from the model
*/

`timescale 1ns/1ps

module asg_checker
  import asg_io_pkg::*;
  import asg_cfg_pkg::*;
#(
  parameter int unsigned TN  = 2,
  parameter int unsigned CWM = 8,
  parameter int unsigned CWF = 8
) (
  input  logic               sto,
  input  logic               ctl_rst,
  input  cpu_req_t           cpu_req,
  input  cpu_rsp_t           cpu_rsp,
  input  logic [TN-1:0]      trg_in,
  input  logic [TN-1:0]      cfg_trg,
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_stp,
  input  logic [CWM+CWF-1:0] cfg_off,
  input  burst_cfg_t         cfg_burst,
  input  sto_beat_t          sto_out,
  input  logic               trg_out,
  input  logic               irq_trg,
  input  logic               irq_stp,
  output int                 err_cnt
);

  // mirror of the table
  sample_t   mem [0:2**CWM-1];
  sample_t   rd_exp;
  logic      rd_pend = 1'b0;
  logic      ack_exp = 1'b0;
  logic      trg_exp = 1'b0;
  logic      rst_d   = 1'b0;
  // edges since the start trigger, 0 when none pending
  int        lat     = 0;
  // beat index within the run
  int        k       = 0;
  int        errs    = 0;
  sto_beat_t exp_b;

  assign err_cnt = errs;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %s got %0h expected %0h at %0t", name, got, exp, $time);
    errs++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s at %0t", msg, $time);
    errs++;
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // beats in a finite burst run
  function automatic int burst_beats();
    return (int'(cfg_burst.bln) + 1) * (int'(cfg_burst.bnm) + 1);
  endfunction

  // expected beat idx of a run: step from the offset, modulo size+1
  function automatic sto_beat_t ref_beat(input int idx);
    int        n;
    int        p;
    sto_beat_t b;
    n = idx;
    // burst: fresh reads for bdl+1 cycles of each period, then hold
    if (cfg_burst.ben) begin
      n = idx % (int'(cfg_burst.bln) + 1);
      if (n > int'(cfg_burst.bdl)) begin
        n = int'(cfg_burst.bdl);
      end
    end
    p = int'(cfg_off);
    repeat (n) begin
      p = p + int'(cfg_stp) + 1;
      if (p >= int'(cfg_siz) + 1) begin
        p = p - int'(cfg_siz) - 1;
      end
    end
    b.tvalid = 1'b1;
    b.tdata  = mem[CWM'(p >> CWF)];
    b.tlast  = cfg_burst.ben & ~cfg_burst.inf & (idx == burst_beats() - 1);
    return b;
  endfunction

  //////////////////////////////
  // compare
  //////////////////////////////

  // ack and read data one cycle after the strobe
  task automatic check_bus();
    if (cpu_rsp.ack !== ack_exp) begin
      report_mismatch("cpu_rsp.ack", 32'(cpu_rsp.ack), 32'(ack_exp));
    end
    if (rd_pend && cpu_rsp.rdata !== rd_exp) begin
      report_mismatch("cpu_rsp.rdata", 32'(cpu_rsp.rdata), 32'(rd_exp));
    end
    ack_exp = cpu_req.wen | cpu_req.ren;
    rd_pend = cpu_req.ren;
    if (cpu_req.ren) begin
      rd_exp = mem[cpu_req.addr[CWM-1:0]];
    end
    // trg_out follows irq_trg by one edge
    if (trg_out !== trg_exp) begin
      report_mismatch("trg_out", 32'(trg_out), 32'(trg_exp));
    end
    trg_exp = irq_trg;
  endtask

  task automatic check_beat();
    if (sto_out.tvalid === 1'b1) begin
      if (k == 0 && lat != 3) begin
        report_fault("first beat did not come 3 edges after a trigger");
      end
      lat = 0;
      if (cfg_burst.ben && !cfg_burst.inf && k >= burst_beats()) begin
        report_fault("valid beat after the tlast beat");
      end else begin
        exp_b = ref_beat(k);
        if (sto_out.tdata !== exp_b.tdata) begin
          report_mismatch($sformatf("sto_out.tdata beat %0d", k),
                          32'(sto_out.tdata), 32'(exp_b.tdata));
        end
        if (sto_out.tlast !== exp_b.tlast || irq_stp !== exp_b.tlast) begin
          report_mismatch($sformatf("sto_out.tlast/irq_stp beat %0d", k),
                          32'({sto_out.tlast, irq_stp}), 32'({2{exp_b.tlast}}));
        end
      end
      k++;
    end else begin
      k = 0;
      if (irq_stp !== 1'b0) begin
        report_mismatch("irq_stp", 32'(irq_stp), 32'h0);
      end
      if (lat != 0) begin
        lat++;
        if (lat > 3) begin
          report_fault("no beat 3 edges after the trigger");
          lat = 0;
        end
      end else if (irq_trg !== |(trg_in & cfg_trg)) begin
        // idle, so irq_trg is the masked trigger
        report_mismatch("irq_trg", 32'(irq_trg), 32'(|(trg_in & cfg_trg)));
      end
      if (irq_trg === 1'b1 && lat == 0) begin
        lat = 1;
      end
    end
  endtask

  always @(posedge sto) begin
    // tvalid drops on the reset edge
    if (rst_d && sto_out.tvalid !== 1'b0) begin
      report_fault("tvalid still high after the reset edge");
    end
    rst_d = ctl_rst;
    // table keeps its contents over reset
    if (cpu_req.wen) begin
      mem[cpu_req.addr[CWM-1:0]] = cpu_req.wdata;
    end
    if (ctl_rst) begin
      ack_exp = 1'b0;
      rd_pend = 1'b0;
      trg_exp = 1'b0;
      lat     = 0;
      k       = 0;
    end else begin
      check_bus();
      check_beat();
    end
  end

endmodule

// ==== dv/asg_tb.sv ====
/*
  testbench for one generator channel, table filled from $urandom
  inputs change just after the rising edge, all compares are in asg_checker
*/

`timescale 1ns/1ps

module asg_tb
  import asg_io_pkg::*;
  import asg_cfg_pkg::*;
();

  localparam int unsigned TN  = 2;
  localparam int unsigned CWM = 8;
  localparam int unsigned CWF = 8;
  // rough test lengths in cycles, reset and bus test first
  localparam int TEST_CYCLES = 16 + 4 * 2**CWM + 50 + 95 + 70 + 70 + 85;

  logic               sto;
  logic               ctl_rst;
  cpu_req_t           cpu_req;
  cpu_rsp_t           cpu_rsp;
  logic [TN-1:0]      trg_in;
  logic [TN-1:0]      cfg_trg;
  logic [CWM+CWF-1:0] cfg_siz;
  logic [CWM+CWF-1:0] cfg_stp;
  logic [CWM+CWF-1:0] cfg_off;
  burst_cfg_t         cfg_burst;
  sto_beat_t          sto_out;
  logic               trg_out;
  logic               irq_trg;
  logic               irq_stp;
  int                 err_cnt;
  int                 tb_err   = 0;
  int                 err_mark = 0;
  int                 n_tests  = 0;
  int                 n_bad    = 0;

  asg_top #(.TN(TN), .CWM(CWM), .CWF(CWF)) asg_top_inst (.*);
  asg_checker #(.TN(TN), .CWM(CWM), .CWF(CWF)) asg_checker_inst (.*);

  initial begin
    sto = 1'b0;
    forever #50 sto = ~sto;
  end

  // watchdog
  initial begin
    repeat (TEST_CYCLES + 200) @(posedge sto);
    $display("watchdog: the run did not finish in time");
    $display("test failed");
    $finish;
  end

  task automatic tick(input int n);
    repeat (n) @(posedge sto);
  endtask

  // one strobe, then an idle cycle
  task automatic bus_access(input logic wr, input int a, input sample_t d);
    cpu_req <= '{wen: wr, ren: ~wr, addr: cpu_addr_t'(a), wdata: d};
    tick(1);
    cpu_req <= '0;
    tick(1);
  endtask

  task automatic pulse_trg(input logic [TN-1:0] t);
    trg_in <= t;
    tick(1);
    trg_in <= '0;
  endtask

  task automatic set_cfg(input logic [CWM+CWF-1:0] siz, input logic [CWM+CWF-1:0] stp,
                         input logic [CWM+CWF-1:0] off, input burst_cfg_t b);
    cfg_siz   <= siz;
    cfg_stp   <= stp;
    cfg_off   <= off;
    cfg_burst <= b;
    tick(1);
  endtask

  // one cycle of reset ends any run
  task automatic stop_run();
    ctl_rst <= 1'b1;
    tick(1);
    ctl_rst <= 1'b0;
    tick(1);
  endtask

  // burst end, sampled away from the rising edge
  task automatic wait_stop(input int max_cycles);
    int n;
    n = 0;
    @(negedge sto);
    while (irq_stp !== 1'b1 && n < max_cycles) begin
      @(negedge sto);
      n++;
    end
    if (irq_stp !== 1'b1) begin
      $display("burst did not raise irq_stp within %0d cycles", max_cycles);
      tb_err++;
    end
    @(posedge sto);
  endtask

  task automatic report_test(input int num, input string name);
    int e;
    @(negedge sto);
    e = err_cnt + tb_err;
    n_tests++;
    if (e == err_mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      n_bad++;
      $display("test %0d %s: %0d errors", num, name, e - err_mark);
    end
    err_mark = e;
    @(posedge sto);
  endtask

  initial begin
    void'($urandom(32'h25988278));
    ctl_rst   = 1'b1;
    cpu_req   = '0;
    trg_in    = '0;
    cfg_trg   = 2'b01;
    cfg_siz   = '1;
    cfg_stp   = 16'h00FF;
    cfg_off   = '0;
    cfg_burst = '0;
    tick(16);
    ctl_rst <= 1'b0;
    tick(1);

    //////////////////////////////
    for (int i = 0; i < 2**CWM; i++) begin
      bus_access(1'b1, i, sample_t'($urandom));
    end
    for (int i = 0; i < 2**CWM; i++) begin
      bus_access(1'b0, i, '0);
    end
    report_test(1, "bus write and read-back");

    // 16 entries, step 1.0
    set_cfg(16'h0FFF, 16'h00FF, 16'h0000, '0);
    pulse_trg(2'b01);
    tick(45);
    stop_run();
    report_test(2, "periodic integer step");

    // 40 entries, step 0.375 from 10.5
    set_cfg(16'h27FF, 16'h005F, 16'h0A80, '0);
    pulse_trg(2'b01);
    tick(90);
    stop_run();
    report_test(3, "periodic fractional step");

    // 3 periods of 10, 5 fresh samples each, step 1.5
    set_cfg(16'hFFFF, 16'h017F, 16'h2000, '{1'b1, 1'b0, 32'd4, 32'd9, 16'd2});
    pulse_trg(2'b01);
    wait_stop(40);
    tick(20);
    report_test(4, "finite burst");

    //////////////////////////////
    cfg_trg <= 2'b10;
    set_cfg(16'h27FF, 16'h005F, 16'h0A80, '0);
    pulse_trg(2'b01);
    tick(10);
    pulse_trg(2'b10);
    tick(20);
    // ignored while running
    pulse_trg(2'b11);
    tick(5);
    pulse_trg(2'b10);
    tick(20);
    stop_run();
    report_test(5, "trigger masking");

    cfg_trg <= 2'b01;
    set_cfg(16'h0FFF, 16'h00FF, 16'h0300, '{1'b1, 1'b1, 32'd3, 32'd7, 16'd0});
    pulse_trg(2'b01);
    tick(30);
    stop_run();
    tick(20);
    pulse_trg(2'b01);
    tick(25);
    stop_run();
    report_test(6, "reset during infinite burst");

    $display("%0d tests run, %0d with errors, %0d errors in total",
             n_tests, n_bad, err_mark);
    if (n_bad == 0 && err_mark == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/asg_cfg_pkg.sv
design/asg_io_pkg.sv
design/asg_table.sv
design/asg_sequencer.sv
design/asg_top.sv
dv/asg_checker.sv
dv/asg_tb.sv
